// ==== files.f ====
rvfi_pkg.sv
rvfi_stage_if.sv
rvfi_decode_stage.sv
rvfi_execute_stage.sv
rvfi_retire_stage.sv
rvfi_trace.sv
rvfi_trace_properties.sv
tb_rvfi_trace.sv

// ==== Makefile ====
TOP := tb_rvfi_trace

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --top-module $(TOP) -f files.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

// ==== tb_rvfi_trace.sv ====
module tb_rvfi_trace;
    import rvfi_pkg::*;

    localparam int ORDER_WIDTH = 64;
    localparam int NUM_CYCLES = 5000;
    // reset and stimulus cycles at 20 per cycle plus slack
    localparam int WATCHDOG_TIME = (NUM_CYCLES + 3) * 20 + 2000;

    // one in-flight record as the model keeps it
    typedef struct packed {
        logic [31:0] instr;
        logic        trap;
        logic        intr;
        logic [4:0]  rs1_addr;
        logic [4:0]  rs2_addr;
        logic [31:0] rs1_rdata;
        logic [31:0] rs2_rdata;
        logic [31:0] pc;
        logic [31:0] pc_n;
        logic [31:0] csr_wdata;
        logic [31:0] csr_rdata;
    } rec_t;

    // core side inputs start at zero
    logic clk_i = 1'b0;
    logic rst_n_i = 1'b0;
    logic stall_if_i = 1'b0, stall_id_i = 1'b0, stall_ex_i = 1'b0, stall_mem_i = 1'b0;
    logic flush_id_i = 1'b0, flush_ex_i = 1'b0, flush_mem_i = 1'b0, flush_wb_i = 1'b0;
    logic trap_id_i = 1'b0, trap_ex_i = 1'b0, mem_wen_id_i = 1'b0;
    logic branch_decision_ex_i = 1'b0, valid_mem_i = 1'b0;
    logic dmem_wen_i = 1'b0, reg_wen_wb_i = 1'b0;
    logic [4:0] rs1_addr_id_i = '0, rs2_addr_id_i = '0, rd_addr_wb_i = '0;
    logic [3:0] dmem_ben_i = '0;
    logic [31:0] instr_id_i = '0, pc_if_i = '0, pc_id_i = '0, jump_target_id_i = '0;
    logic [31:0] rs1_rdata_id_i = '0, rs2_rdata_id_i = '0, branch_target_ex_i = '0;
    logic [31:0] csr_wdata_ex_i = '0, csr_rdata_ex_i = '0;
    logic [31:0] dmem_addr_i = '0, dmem_wdata_i = '0;
    logic [31:0] reg_wdata_wb_i = '0, mem_rdata_wb_i = '0;
    next_pc_mux_t next_pc_mux_i = NPC_SEQ;
    alu_source_1_t alu_source_1_id_i = ALU_SRC1_RS1;
    alu_source_2_t alu_source_2_id_i = ALU_SRC2_RS2;
    pc_source_t pc_source_id_i = PC_SEQ;

    // trace side
    logic rvfi_valid_o, rvfi_trap_o, rvfi_intr_o;
    logic [ORDER_WIDTH-1:0] rvfi_order_o;
    logic [4:0] rvfi_rs1_addr_o, rvfi_rs2_addr_o, rvfi_rd_addr_o;
    logic [3:0] rvfi_mem_rmask_o, rvfi_mem_wmask_o;
    logic [31:0] rvfi_insn_o, rvfi_rs1_rdata_o, rvfi_rs2_rdata_o, rvfi_rd_wdata_o;
    logic [31:0] rvfi_pc_rdata_o, rvfi_pc_wdata_o, rvfi_mem_addr_o, rvfi_mem_rdata_o;
    logic [31:0] rvfi_mem_wdata_o, rvfi_csr_rmask_o, rvfi_csr_rdata_o;
    logic [31:0] rvfi_csr_wmask_o, rvfi_csr_wdata_o;

    int seed = 32'hfecf_eab3;
    int cycle = 0;
    int checks = 0;
    int errors = 0;

    // model state for the ex, mem and wb registers
    logic m_intr_if, m_intr_id, m_valid_wb;
    rec_t m_ex, m_mem, m_wb;
    logic [31:0] m_mem_addr, m_mem_wdata;
    logic [3:0] m_rmask, m_wmask;
    logic [ORDER_WIDTH-1:0] m_order;

    rvfi_trace #(
        .ORDER_WIDTH (ORDER_WIDTH)
    ) rvfi_trace_i (
        .*
    );

    initial begin
        forever begin
            #10;
            clk_i = ~clk_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // random stimulus
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    // each bit set about one time in eight
    function automatic logic [9:0] rare_bits();
        logic [9:0] b;
        for (int i = 0; i < 10; i++) begin
            b[i] = (rand_word() & 32'h7) == 32'h0;
        end
        return b;
    endfunction

    task automatic drive_random();
        logic [31:0] r;
        logic [9:0]  rare;
        r = rand_word();
        rare = rare_bits();
        {stall_if_i, stall_id_i, stall_ex_i, stall_mem_i} <= rare[3:0];
        {flush_id_i, flush_ex_i, flush_mem_i, flush_wb_i} <= rare[7:4];
        {trap_id_i, trap_ex_i} <= rare[9:8];
        {valid_mem_i, dmem_wen_i, reg_wen_wb_i, mem_wen_id_i, branch_decision_ex_i} <= r[4:0];
        dmem_ben_i        <= r[8:5];
        rs1_addr_id_i     <= r[13:9];
        rs2_addr_id_i     <= r[18:14];
        // x0 about one time in 32
        rd_addr_wb_i      <= r[23:19];
        next_pc_mux_i     <= next_pc_mux_t'(r[25:24]);
        pc_source_id_i    <= pc_source_t'(r[27:26]);
        alu_source_2_id_i <= alu_source_2_t'(r[28]);
        // only three legal first sources
        alu_source_1_id_i <= alu_source_1_t'(2'(r[31:29] % 3'd3));
        {instr_id_i, pc_if_i, pc_id_i} <= {rand_word(), rand_word(), rand_word()};
        {rs1_rdata_id_i, rs2_rdata_id_i} <= {rand_word(), rand_word()};
        {jump_target_id_i, branch_target_ex_i} <= {rand_word(), rand_word()};
        {csr_wdata_ex_i, csr_rdata_ex_i} <= {rand_word(), rand_word()};
        {dmem_addr_i, dmem_wdata_i} <= {rand_word(), rand_word()};
        {reg_wdata_wb_i, mem_rdata_wb_i} <= {rand_word(), rand_word()};
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // bubble keeps only pc and the flags
    function automatic rec_t to_bubble(rec_t r);
        rec_t b;
        b = '0;
        b.trap = r.trap;
        b.intr = r.intr;
        b.pc   = r.pc;
        return b;
    endfunction

    task automatic reset_model();
        m_intr_if   = 1'b0;
        m_intr_id   = 1'b0;
        m_valid_wb  = 1'b0;
        m_ex        = '0;
        m_mem       = '0;
        m_wb        = '0;
        m_mem_addr  = '0;
        m_mem_wdata = '0;
        m_rmask     = '0;
        m_wmask     = '0;
        m_order     = '0;
    endtask

    // downstream first so every stage reads its old upstream value
    task automatic step_model();
        logic use_rs1;
        logic use_rs2;
        m_order = m_order + ORDER_WIDTH'(m_valid_wb | m_wb.trap);
        // mem to wb never stalls
        if (flush_wb_i) begin
            m_wb        = to_bubble(m_mem);
            m_valid_wb  = 1'b0;
            m_mem_addr  = '0;
            m_mem_wdata = '0;
            m_rmask     = '0;
            m_wmask     = '0;
        end else begin
            m_wb        = m_mem;
            m_valid_wb  = valid_mem_i;
            m_mem_addr  = dmem_addr_i;
            m_mem_wdata = dmem_wdata_i;
            m_rmask     = dmem_ben_i;
            m_wmask     = dmem_wen_i ? dmem_ben_i : 4'd0;
        end
        // ex to mem
        if (!stall_mem_i) begin
            m_mem = m_ex;
            m_mem.trap = m_ex.trap | (trap_ex_i & ~stall_ex_i);
            m_mem.csr_wdata = csr_wdata_ex_i;
            m_mem.csr_rdata = csr_rdata_ex_i;
            if (branch_decision_ex_i) begin
                m_mem.pc_n = branch_target_ex_i;
            end
            if (flush_mem_i) begin
                m_mem = to_bubble(m_mem);
            end
        end
        // id to ex with operand masking
        if (!stall_ex_i) begin
            use_rs1 = (alu_source_1_id_i == ALU_SRC1_RS1) || (pc_source_id_i == PC_JALR);
            use_rs2 = (alu_source_2_id_i == ALU_SRC2_RS2) || mem_wen_id_i;
            m_ex = '0;
            m_ex.instr = instr_id_i;
            m_ex.trap = trap_id_i & ~stall_id_i & ~branch_decision_ex_i;
            m_ex.intr = m_intr_id;
            m_ex.rs1_addr = use_rs1 ? rs1_addr_id_i : 5'd0;
            m_ex.rs1_rdata = use_rs1 ? rs1_rdata_id_i : 32'd0;
            m_ex.rs2_addr = use_rs2 ? rs2_addr_id_i : 5'd0;
            m_ex.rs2_rdata = use_rs2 ? rs2_rdata_id_i : 32'd0;
            m_ex.pc = pc_id_i;
            // jumps take the decode target
            if ((pc_source_id_i == PC_JAL) || (pc_source_id_i == PC_JALR)) begin
                m_ex.pc_n = jump_target_id_i;
            end else begin
                m_ex.pc_n = pc_if_i;
            end
            if (flush_ex_i) begin
                m_ex = to_bubble(m_ex);
            end
        end
        // interrupt flag from if to id
        if (!stall_id_i) begin
            m_intr_id = flush_id_i ? 1'b0 : m_intr_if;
        end
        if (!stall_if_i) begin
            m_intr_if = (next_pc_mux_i == NPC_EXCEPTION);
        end
    endtask

    // model steps on the inputs the DUT sees at this edge
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            reset_model();
        end else begin
            step_model();
        end
        if (cycle == 2) begin
            rst_n_i <= 1'b1;
        end
        drive_random();
        cycle++;
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s at %0t: expected %h, actual %h", name, $time, expected, actual);
        end
    endtask

    task automatic compare_outputs();
        logic [4:0] exp_rd;
        // wb fields pass straight through
        exp_rd = reg_wen_wb_i ? rd_addr_wb_i : 5'd0;
        check_value("valid", 64'(m_valid_wb | m_wb.trap), 64'(rvfi_valid_o));
        check_value("order", 64'(m_order), 64'(rvfi_order_o));
        check_value("insn", 64'(m_wb.instr), 64'(rvfi_insn_o));
        check_value("trap", 64'(m_wb.trap), 64'(rvfi_trap_o));
        check_value("intr", 64'(m_wb.intr), 64'(rvfi_intr_o));
        check_value("rs1_addr", 64'(m_wb.rs1_addr), 64'(rvfi_rs1_addr_o));
        check_value("rs1_rdata", 64'(m_wb.rs1_rdata), 64'(rvfi_rs1_rdata_o));
        check_value("rs2_addr", 64'(m_wb.rs2_addr), 64'(rvfi_rs2_addr_o));
        check_value("rs2_rdata", 64'(m_wb.rs2_rdata), 64'(rvfi_rs2_rdata_o));
        check_value("rd_addr", 64'(exp_rd), 64'(rvfi_rd_addr_o));
        check_value("rd_wdata", (exp_rd == 5'd0) ? 64'd0 : 64'(reg_wdata_wb_i),
                    64'(rvfi_rd_wdata_o));
        check_value("pc_rdata", 64'(m_wb.pc), 64'(rvfi_pc_rdata_o));
        check_value("pc_wdata", 64'(m_wb.pc_n), 64'(rvfi_pc_wdata_o));
        check_value("mem_addr", 64'(m_mem_addr), 64'(rvfi_mem_addr_o));
        check_value("mem_rmask", 64'(m_rmask), 64'(rvfi_mem_rmask_o));
        check_value("mem_wmask", 64'(m_wmask), 64'(rvfi_mem_wmask_o));
        check_value("mem_rdata", 64'(mem_rdata_wb_i), 64'(rvfi_mem_rdata_o));
        check_value("mem_wdata", 64'(m_mem_wdata), 64'(rvfi_mem_wdata_o));
        // whole csr group on a live record
        check_value("csr_rmask", 64'({32{m_valid_wb}}), 64'(rvfi_csr_rmask_o));
        check_value("csr_wmask", 64'({32{m_valid_wb}}), 64'(rvfi_csr_wmask_o));
        check_value("csr_rdata", 64'(m_wb.csr_rdata), 64'(rvfi_csr_rdata_o));
        check_value("csr_wdata", 64'(m_wb.csr_wdata), 64'(rvfi_csr_wdata_o));
    endtask

    // outputs are settled mid-cycle
    always @(negedge clk_i) begin
        compare_outputs();
    end

    initial begin
        repeat (3 + NUM_CYCLES) @(posedge clk_i);
        // retire stage assertion failures
        errors += rvfi_trace_i.retire_i.retire_props_i.fail_count;
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_TIME);
        $display("timeout: stimulus did not complete within %0d time units", WATCHDOG_TIME);
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== rvfi_trace_properties.sv ====
module rvfi_trace_properties #(
    parameter int ORDER_WIDTH = 64
) (
    input logic                   clk_i,
    input logic                   rst_n_i,
    input logic                   rvfi_valid_o,
    input logic [ORDER_WIDTH-1:0] rvfi_order_o,
    input logic [4:0]             rvfi_rd_addr_o,
    input logic [31:0]            rvfi_rd_wdata_o,
    input logic [3:0]             rvfi_mem_rmask_o,
    input logic [3:0]             rvfi_mem_wmask_o
);

    // failed assertions so far
    int fail_count = 0;

    // first edge out of reset
    valid_after_reset: assert property (@(posedge clk_i) $rose(rst_n_i) |-> !rvfi_valid_o)
        else begin
            $error("trace valid high in the cycle after reset");
            fail_count++;
        end

    wmask_in_rmask: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (rvfi_mem_wmask_o & ~rvfi_mem_rmask_o) == 4'd0)
        else begin
            $error("memory write mask outside the read mask");
            fail_count++;
        end

    // x0 never carries data
    rd_x0_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (rvfi_rd_addr_o == 5'd0) |-> (rvfi_rd_wdata_o == 32'd0))
        else begin
            $error("rd data nonzero for x0");
            fail_count++;
        end

    order_step: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rvfi_valid_o |=> (rvfi_order_o == $past(rvfi_order_o) + ORDER_WIDTH'(1)))
        else begin
            $error("order did not step by one after a valid cycle");
            fail_count++;
        end

    order_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !rvfi_valid_o |=> (rvfi_order_o == $past(rvfi_order_o)))
        else begin
            $error("order moved without a valid cycle");
            fail_count++;
        end

endmodule

bind rvfi_retire_stage rvfi_trace_properties #(
    .ORDER_WIDTH (ORDER_WIDTH)
) retire_props_i (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .rvfi_valid_o     (rvfi_valid_o),
    .rvfi_order_o     (rvfi_order_o),
    .rvfi_rd_addr_o   (rvfi_rd_addr_o),
    .rvfi_rd_wdata_o  (rvfi_rd_wdata_o),
    .rvfi_mem_rmask_o (rvfi_mem_rmask_o),
    .rvfi_mem_wmask_o (rvfi_mem_wmask_o)
);

// ==== rvfi_trace.sv ====
module rvfi_trace #(
    parameter int ORDER_WIDTH = 64
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    // if
    input  logic                        stall_if_i,
    input  logic [rvfi_pkg::XLEN-1:0]   pc_if_i,
    input  rvfi_pkg::next_pc_mux_t      next_pc_mux_i,
    // id
    input  logic                        stall_id_i,
    input  logic                        flush_id_i,
    input  logic                        trap_id_i,
    input  logic [31:0]                 instr_id_i,
    input  rvfi_pkg::alu_source_1_t     alu_source_1_id_i,
    input  rvfi_pkg::alu_source_2_t     alu_source_2_id_i,
    input  logic [4:0]                  rs1_addr_id_i,
    input  logic [4:0]                  rs2_addr_id_i,
    input  logic [rvfi_pkg::XLEN-1:0]   rs1_rdata_id_i,
    input  logic [rvfi_pkg::XLEN-1:0]   rs2_rdata_id_i,
    input  logic [rvfi_pkg::XLEN-1:0]   pc_id_i,
    input  rvfi_pkg::pc_source_t        pc_source_id_i,
    input  logic [rvfi_pkg::XLEN-1:0]   jump_target_id_i,
    input  logic                        mem_wen_id_i,
    // ex
    input  logic                        stall_ex_i,
    input  logic                        flush_ex_i,
    input  logic                        trap_ex_i,
    input  logic [rvfi_pkg::XLEN-1:0]   branch_target_ex_i,
    input  logic                        branch_decision_ex_i,
    input  logic [rvfi_pkg::XLEN-1:0]   csr_wdata_ex_i,
    input  logic [rvfi_pkg::XLEN-1:0]   csr_rdata_ex_i,
    // mem
    input  logic                        stall_mem_i,
    input  logic                        flush_mem_i,
    input  logic                        valid_mem_i,
    input  logic [rvfi_pkg::XLEN-1:0]   dmem_addr_i,
    input  logic [rvfi_pkg::XLEN-1:0]   dmem_wdata_i,
    input  logic                        dmem_wen_i,
    input  logic [rvfi_pkg::XLEN/8-1:0] dmem_ben_i,
    // wb
    input  logic                        flush_wb_i,
    input  logic [4:0]                  rd_addr_wb_i,
    input  logic                        reg_wen_wb_i,
    input  logic [rvfi_pkg::XLEN-1:0]   reg_wdata_wb_i,
    input  logic [rvfi_pkg::XLEN-1:0]   mem_rdata_wb_i,
    // trace
    output logic                        rvfi_valid_o,
    output logic [ORDER_WIDTH-1:0]      rvfi_order_o,
    output logic [31:0]                 rvfi_insn_o,
    output logic                        rvfi_trap_o,
    output logic                        rvfi_intr_o,
    output logic [4:0]                  rvfi_rs1_addr_o,
    output logic [rvfi_pkg::XLEN-1:0]   rvfi_rs1_rdata_o,
    output logic [4:0]                  rvfi_rs2_addr_o,
    output logic [rvfi_pkg::XLEN-1:0]   rvfi_rs2_rdata_o,
    output logic [4:0]                  rvfi_rd_addr_o,
    output logic [rvfi_pkg::XLEN-1:0]   rvfi_rd_wdata_o,
    output logic [rvfi_pkg::XLEN-1:0]   rvfi_pc_rdata_o,
    output logic [rvfi_pkg::XLEN-1:0]   rvfi_pc_wdata_o,
    output logic [rvfi_pkg::XLEN-1:0]   rvfi_mem_addr_o,
    output logic [rvfi_pkg::XLEN/8-1:0] rvfi_mem_rmask_o,
    output logic [rvfi_pkg::XLEN-1:0]   rvfi_mem_rdata_o,
    output logic [rvfi_pkg::XLEN/8-1:0] rvfi_mem_wmask_o,
    output logic [rvfi_pkg::XLEN-1:0]   rvfi_mem_wdata_o,
    output logic [rvfi_pkg::XLEN-1:0]   rvfi_csr_rmask_o,
    output logic [rvfi_pkg::XLEN-1:0]   rvfi_csr_rdata_o,
    output logic [rvfi_pkg::XLEN-1:0]   rvfi_csr_wmask_o,
    output logic [rvfi_pkg::XLEN-1:0]   rvfi_csr_wdata_o
);

    // record registers between stages
    rvfi_stage_if id_ex ();
    rvfi_stage_if ex_mem ();

    // port names match the core side, so connect by name
    rvfi_decode_stage decode_i (
        .*,
        .id_ex (id_ex.src)
    );

    rvfi_execute_stage execute_i (
        .*,
        .id_ex  (id_ex.dst),
        .ex_mem (ex_mem.src)
    );

    rvfi_retire_stage #(
        .ORDER_WIDTH (ORDER_WIDTH)
    ) retire_i (
        .*,
        .ex_mem (ex_mem.dst)
    );

endmodule

// ==== rvfi_retire_stage.sv ====
module rvfi_retire_stage #(
    parameter int ORDER_WIDTH = 64
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        flush_wb_i,
    input  logic                        valid_mem_i,
    input  logic [rvfi_pkg::XLEN-1:0]   dmem_addr_i,
    input  logic [rvfi_pkg::XLEN-1:0]   dmem_wdata_i,
    input  logic                        dmem_wen_i,
    input  logic [rvfi_pkg::XLEN/8-1:0] dmem_ben_i,
    input  logic [4:0]                  rd_addr_wb_i,
    input  logic                        reg_wen_wb_i,
    input  logic [rvfi_pkg::XLEN-1:0]   reg_wdata_wb_i,
    input  logic [rvfi_pkg::XLEN-1:0]   mem_rdata_wb_i,
    rvfi_stage_if.dst                   ex_mem,
    output logic                        rvfi_valid_o,
    output logic [ORDER_WIDTH-1:0]      rvfi_order_o,
    output logic [31:0]                 rvfi_insn_o,
    output logic                        rvfi_trap_o,
    output logic                        rvfi_intr_o,
    output logic [4:0]                  rvfi_rs1_addr_o,
    output logic [rvfi_pkg::XLEN-1:0]   rvfi_rs1_rdata_o,
    output logic [4:0]                  rvfi_rs2_addr_o,
    output logic [rvfi_pkg::XLEN-1:0]   rvfi_rs2_rdata_o,
    output logic [4:0]                  rvfi_rd_addr_o,
    output logic [rvfi_pkg::XLEN-1:0]   rvfi_rd_wdata_o,
    output logic [rvfi_pkg::XLEN-1:0]   rvfi_pc_rdata_o,
    output logic [rvfi_pkg::XLEN-1:0]   rvfi_pc_wdata_o,
    output logic [rvfi_pkg::XLEN-1:0]   rvfi_mem_addr_o,
    output logic [rvfi_pkg::XLEN/8-1:0] rvfi_mem_rmask_o,
    output logic [rvfi_pkg::XLEN-1:0]   rvfi_mem_rdata_o,
    output logic [rvfi_pkg::XLEN/8-1:0] rvfi_mem_wmask_o,
    output logic [rvfi_pkg::XLEN-1:0]   rvfi_mem_wdata_o,
    output logic [rvfi_pkg::XLEN-1:0]   rvfi_csr_rmask_o,
    output logic [rvfi_pkg::XLEN-1:0]   rvfi_csr_rdata_o,
    output logic [rvfi_pkg::XLEN-1:0]   rvfi_csr_wmask_o,
    output logic [rvfi_pkg::XLEN-1:0]   rvfi_csr_wdata_o
);
    import rvfi_pkg::*;

    // mem stage valid, low on a wb bubble
    logic valid_wb;

    ////////////////////////////////////////////////////////////
    // mem to wb record, never stalls
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_wb         <= 1'b0;
            rvfi_order_o     <= '0;
            rvfi_insn_o      <= '0;
            rvfi_trap_o      <= 1'b0;
            rvfi_intr_o      <= 1'b0;
            rvfi_rs1_addr_o  <= '0;
            rvfi_rs2_addr_o  <= '0;
            rvfi_rs1_rdata_o <= '0;
            rvfi_rs2_rdata_o <= '0;
            rvfi_pc_rdata_o  <= '0;
            rvfi_pc_wdata_o  <= '0;
            rvfi_mem_addr_o  <= '0;
            rvfi_mem_rmask_o <= '0;
            rvfi_mem_wmask_o <= '0;
            rvfi_mem_wdata_o <= '0;
            rvfi_csr_wdata_o <= '0;
            rvfi_csr_rdata_o <= '0;
        end else begin
            // one step per retired record
            rvfi_order_o    <= rvfi_order_o + ORDER_WIDTH'(rvfi_valid_o);
            rvfi_trap_o     <= ex_mem.trap;
            rvfi_intr_o     <= ex_mem.intr;
            rvfi_pc_rdata_o <= ex_mem.pc;
            if (flush_wb_i) begin
                valid_wb         <= 1'b0;
                rvfi_insn_o      <= '0;
                rvfi_rs1_addr_o  <= '0;
                rvfi_rs2_addr_o  <= '0;
                rvfi_rs1_rdata_o <= '0;
                rvfi_rs2_rdata_o <= '0;
                rvfi_pc_wdata_o  <= '0;
                rvfi_mem_addr_o  <= '0;
                rvfi_mem_rmask_o <= '0;
                rvfi_mem_wmask_o <= '0;
                rvfi_mem_wdata_o <= '0;
                rvfi_csr_wdata_o <= '0;
                rvfi_csr_rdata_o <= '0;
            end else begin
                valid_wb         <= valid_mem_i;
                rvfi_insn_o      <= ex_mem.instr;
                rvfi_rs1_addr_o  <= ex_mem.rs1_addr;
                rvfi_rs2_addr_o  <= ex_mem.rs2_addr;
                rvfi_rs1_rdata_o <= ex_mem.rs1_rdata;
                rvfi_rs2_rdata_o <= ex_mem.rs2_rdata;
                rvfi_pc_wdata_o  <= ex_mem.pc_n;
                // data memory access as seen in mem
                rvfi_mem_addr_o  <= dmem_addr_i;
                rvfi_mem_rmask_o <= dmem_ben_i;
                rvfi_mem_wmask_o <= dmem_wen_i ? dmem_ben_i : '0;
                rvfi_mem_wdata_o <= dmem_wdata_i;
                rvfi_csr_wdata_o <= ex_mem.csr_wdata;
                rvfi_csr_rdata_o <= ex_mem.csr_rdata;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // trace outputs
    ////////////////////////////////////////////////////////////

    // a trap retires even without a valid mem instr
    assign rvfi_valid_o = valid_wb || rvfi_trap_o;

    // wb results pass straight through
    assign rvfi_rd_addr_o   = reg_wen_wb_i ? rd_addr_wb_i : 5'd0;
    // x0 always reads as zero
    assign rvfi_rd_wdata_o  = (rvfi_rd_addr_o == 5'd0) ? '0 : reg_wdata_wb_i;
    assign rvfi_mem_rdata_o = mem_rdata_wb_i;

    // single csr group, fully covered on a live record
    assign rvfi_csr_rmask_o = {XLEN{valid_wb}};
    assign rvfi_csr_wmask_o = {XLEN{valid_wb}};

endmodule

// ==== rvfi_execute_stage.sv ====
module rvfi_execute_stage (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      stall_ex_i,
    input  logic                      stall_mem_i,
    input  logic                      flush_mem_i,
    input  logic                      trap_ex_i,
    input  logic [rvfi_pkg::XLEN-1:0] branch_target_ex_i,
    input  logic                      branch_decision_ex_i,
    input  logic [rvfi_pkg::XLEN-1:0] csr_wdata_ex_i,
    input  logic [rvfi_pkg::XLEN-1:0] csr_rdata_ex_i,
    rvfi_stage_if.dst                 id_ex,
    rvfi_stage_if.src                 ex_mem
);

    ////////////////////////////////////////////////////////////
    // ex to mem record
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_mem.instr     <= '0;
            ex_mem.trap      <= 1'b0;
            ex_mem.intr      <= 1'b0;
            ex_mem.rs1_addr  <= '0;
            ex_mem.rs2_addr  <= '0;
            ex_mem.rs1_rdata <= '0;
            ex_mem.rs2_rdata <= '0;
            ex_mem.pc        <= '0;
            ex_mem.pc_n      <= '0;
            ex_mem.csr_wdata <= '0;
            ex_mem.csr_rdata <= '0;
        end else if (!stall_mem_i) begin
            // trap from id or raised here
            // a stalled ex has not committed its trap yet
            ex_mem.trap <= id_ex.trap || (trap_ex_i && !stall_ex_i);
            ex_mem.intr <= id_ex.intr;
            ex_mem.pc   <= id_ex.pc;
            if (flush_mem_i) begin
                // bubble
                ex_mem.instr     <= '0;
                ex_mem.rs1_addr  <= '0;
                ex_mem.rs2_addr  <= '0;
                ex_mem.rs1_rdata <= '0;
                ex_mem.rs2_rdata <= '0;
                ex_mem.pc_n      <= '0;
                ex_mem.csr_wdata <= '0;
                ex_mem.csr_rdata <= '0;
            end else begin
                ex_mem.instr     <= id_ex.instr;
                ex_mem.rs1_addr  <= id_ex.rs1_addr;
                ex_mem.rs2_addr  <= id_ex.rs2_addr;
                ex_mem.rs1_rdata <= id_ex.rs1_rdata;
                ex_mem.rs2_rdata <= id_ex.rs2_rdata;
                // taken branch overrides the id next pc
                ex_mem.pc_n      <= branch_decision_ex_i ? branch_target_ex_i : id_ex.pc_n;
                ex_mem.csr_wdata <= csr_wdata_ex_i;
                ex_mem.csr_rdata <= csr_rdata_ex_i;
            end
        end
    end

endmodule

// ==== rvfi_decode_stage.sv ====
module rvfi_decode_stage (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      stall_if_i,
    input  logic                      stall_id_i,
    input  logic                      stall_ex_i,
    input  logic                      flush_id_i,
    input  logic                      flush_ex_i,
    input  logic                      trap_id_i,
    input  logic                      branch_decision_ex_i,
    input  rvfi_pkg::next_pc_mux_t    next_pc_mux_i,
    input  logic [31:0]               instr_id_i,
    input  rvfi_pkg::alu_source_1_t   alu_source_1_id_i,
    input  rvfi_pkg::alu_source_2_t   alu_source_2_id_i,
    input  logic [4:0]                rs1_addr_id_i,
    input  logic [4:0]                rs2_addr_id_i,
    input  logic [rvfi_pkg::XLEN-1:0] rs1_rdata_id_i,
    input  logic [rvfi_pkg::XLEN-1:0] rs2_rdata_id_i,
    input  logic [rvfi_pkg::XLEN-1:0] pc_id_i,
    input  logic [rvfi_pkg::XLEN-1:0] pc_if_i,
    input  rvfi_pkg::pc_source_t      pc_source_id_i,
    input  logic [rvfi_pkg::XLEN-1:0] jump_target_id_i,
    input  logic                      mem_wen_id_i,
    rvfi_stage_if.src                 id_ex
);
    import rvfi_pkg::*;

    logic            intr_if;
    logic            intr_id;
    logic            use_rs1;
    logic            use_rs2;
    logic [XLEN-1:0] pc_n_id;

    ////////////////////////////////////////////////////////////
    // interrupt tracking, if and id
    ////////////////////////////////////////////////////////////

    // a redirect to the trap vector marks the fetched instr
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            intr_if <= 1'b0;
        end else if (!stall_if_i) begin
            intr_if <= (next_pc_mux_i == NPC_EXCEPTION);
        end
    end

    // if to id, dropped on flush
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            intr_id <= 1'b0;
        end else if (!stall_id_i) begin
            intr_id <= flush_id_i ? 1'b0 : intr_if;
        end
    end

    ////////////////////////////////////////////////////////////
    // id to ex record
    ////////////////////////////////////////////////////////////

    // operands the instr really reads
    // jalr reads rs1 even though the alu takes the pc
    assign use_rs1 = (alu_source_1_id_i == ALU_SRC1_RS1) || (pc_source_id_i == PC_JALR);
    // stores read rs2 as write data
    assign use_rs2 = (alu_source_2_id_i == ALU_SRC2_RS2) || mem_wen_id_i;

    // jumps resolve here, branches are patched in ex
    assign pc_n_id = (pc_source_id_i inside {PC_JAL, PC_JALR}) ? jump_target_id_i : pc_if_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_ex.instr     <= '0;
            id_ex.trap      <= 1'b0;
            id_ex.intr      <= 1'b0;
            id_ex.rs1_addr  <= '0;
            id_ex.rs2_addr  <= '0;
            id_ex.rs1_rdata <= '0;
            id_ex.rs2_rdata <= '0;
            id_ex.pc        <= '0;
            id_ex.pc_n      <= '0;
        end else if (!stall_ex_i) begin
            // flags and pc move on even through a flush
            // a taken branch in ex kills the id trap
            id_ex.trap <= trap_id_i && !stall_id_i && !branch_decision_ex_i;
            id_ex.intr <= intr_id;
            id_ex.pc   <= pc_id_i;
            if (flush_ex_i) begin
                // bubble
                id_ex.instr     <= '0;
                id_ex.rs1_addr  <= '0;
                id_ex.rs2_addr  <= '0;
                id_ex.rs1_rdata <= '0;
                id_ex.rs2_rdata <= '0;
                id_ex.pc_n      <= '0;
            end else begin
                id_ex.instr     <= instr_id_i;
                id_ex.rs1_addr  <= use_rs1 ? rs1_addr_id_i : 5'd0;
                id_ex.rs1_rdata <= use_rs1 ? rs1_rdata_id_i : '0;
                id_ex.rs2_addr  <= use_rs2 ? rs2_addr_id_i : 5'd0;
                id_ex.rs2_rdata <= use_rs2 ? rs2_rdata_id_i : '0;
                id_ex.pc_n      <= pc_n_id;
            end
        end
    end

    // csr data joins the record in ex
    assign id_ex.csr_wdata = '0;
    assign id_ex.csr_rdata = '0;

endmodule

// ==== rvfi_stage_if.sv ====
interface rvfi_stage_if;
    import rvfi_pkg::*;

    // one in-flight trace record
    logic [31:0]     instr;
    logic            trap;
    logic            intr;
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [XLEN-1:0] rs1_rdata;
    logic [XLEN-1:0] rs2_rdata;
    logic [XLEN-1:0] pc;
    // pc of the next instruction, resolved as the record moves on
    logic [XLEN-1:0] pc_n;
    logic [XLEN-1:0] csr_wdata;
    logic [XLEN-1:0] csr_rdata;

    // stage that owns the register
    modport src (
        output instr, trap, intr,
        output rs1_addr, rs2_addr, rs1_rdata, rs2_rdata,
        output pc, pc_n,
        output csr_wdata, csr_rdata
    );

    // stage downstream of the register
    modport dst (
        input instr, trap, intr,
        input rs1_addr, rs2_addr, rs1_rdata, rs2_rdata,
        input pc, pc_n,
        input csr_wdata, csr_rdata
    );

endinterface

// ==== rvfi_pkg.sv ====
package rvfi_pkg;

    // rvfi field layout is fixed to rv32
    localparam int XLEN = 32;

    // fetch next-pc selection
    typedef enum logic [1:0] {
        NPC_SEQ       = 2'b00,
        NPC_JUMP      = 2'b01,
        NPC_BRANCH    = 2'b10,
        // redirect to the trap vector, taken as an interrupt
        NPC_EXCEPTION = 2'b11
    } next_pc_mux_t;

    // first alu operand
    typedef enum logic [1:0] {
        ALU_SRC1_RS1  = 2'b00,
        ALU_SRC1_PC   = 2'b01,
        ALU_SRC1_ZERO = 2'b10
    } alu_source_1_t;

    // second alu operand
    typedef enum logic {
        ALU_SRC2_RS2 = 1'b0,
        ALU_SRC2_IMM = 1'b1
    } alu_source_2_t;

    // decode pc source
    typedef enum logic [1:0] {
        PC_SEQ    = 2'b00,
        PC_JAL    = 2'b01,
        PC_JALR   = 2'b10,
        PC_BRANCH = 2'b11
    } pc_source_t;

endpackage
